// File: hdl/fifo_pkg.sv
// FIFO shared definitions
`default_nettype none

package fifo_pkg;

  // ----------------------------------------
  // Geometry
  // ----------------------------------------

  // Number of entries
  localparam int DEPTH = 8;
  // Bits per entry
  localparam int DATA_WIDTH = 8;
  // Enough bits to index every entry
  localparam int ADDR_WIDTH = $clog2(DEPTH);
  // Count has to reach DEPTH itself, hence the +1
  localparam int COUNT_WIDTH = $clog2(DEPTH + 1);

  // ----------------------------------------
  // Types
  // ----------------------------------------

  // One payload word
  typedef logic [DATA_WIDTH-1:0] data_t;
  // RAM address
  typedef logic [ADDR_WIDTH-1:0] addr_t;
  // Item count, 0 to DEPTH
  typedef logic [COUNT_WIDTH-1:0] count_t;

  // One RAM write request
  typedef struct packed {
    logic  en;
    addr_t addr;
    data_t data;
  } ram_wr_t;

endpackage

`default_nettype wire

// File: hdl/fifo_ram.sv
// FIFO storage array
`timescale 1ns/1ps
`default_nettype none

module fifo_ram
  import fifo_pkg::*;
(
  input  logic    clk,
  input  logic    rst_n,
  // Write port
  input  ram_wr_t ram_wr,
  // Read port
  input  addr_t   rd_addr,
  output data_t   rd_data
);

  // ----------------------------------------
  // Storage
  // ----------------------------------------

  data_t mem [DEPTH];

  // Write lands at the clock edge
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < DEPTH; i++) begin
        mem[i] <= '0;
      end
    end else if (ram_wr.en) begin
      mem[ram_wr.addr] <= ram_wr.data;
    end
  end

  // ----------------------------------------
  // Read
  // ----------------------------------------

  // Combinational, no read latency
  assign rd_data = mem[rd_addr];

endmodule

`default_nettype wire

// File: hdl/fifo_push_ctrl.sv
// FIFO push controller
`timescale 1ns/1ps
`default_nettype none

module fifo_push_ctrl
  import fifo_pkg::*;
(
  input  logic    clk,
  input  logic    rst_n,
  // Push side
  input  logic    push_valid,
  input  data_t   push_data,
  output logic    push_ready,
  // Status from the occupancy tracker
  input  logic    full,
  // Pop side takes the beat directly
  input  logic    bypass_ready,
  // RAM write port
  output ram_wr_t ram_wr
);

  // ----------------------------------------
  // Handshake
  // ----------------------------------------

  logic  push_beat;
  logic  wr_en;
  addr_t wr_addr;
  addr_t wr_addr_next;

  // Only full blocks a push, pop_ready plays no part
  assign push_ready = !full;
  assign push_beat  = push_valid && push_ready;

  // Bypassed beats never touch the RAM
  assign wr_en = push_beat && !bypass_ready;

  // ----------------------------------------
  // Write address counter
  // ----------------------------------------

  // Wrap explicitly at the last entry
  assign wr_addr_next = (wr_addr == addr_t'(DEPTH - 1)) ? '0 : wr_addr + 1'b1;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_addr <= '0;
    end else if (wr_en) begin
      wr_addr <= wr_addr_next;
    end
  end

  // ----------------------------------------
  // RAM write request
  // ----------------------------------------

  assign ram_wr.en   = wr_en;
  assign ram_wr.addr = wr_addr;
  assign ram_wr.data = push_data;

endmodule

`default_nettype wire

// File: hdl/fifo_pop_ctrl.sv
// FIFO pop controller
`timescale 1ns/1ps
`default_nettype none

module fifo_pop_ctrl
  import fifo_pkg::*;
(
  input  logic  clk,
  input  logic  rst_n,
  // Pop side
  input  logic  pop_ready,
  output logic  pop_valid,
  output data_t pop_data,
  // Incoming push, seen for bypass
  input  logic  push_valid,
  input  data_t push_data,
  output logic  bypass_ready,
  // RAM read port
  output addr_t ram_rd_addr,
  input  data_t ram_rd_data,
  // Status from the occupancy tracker
  input  logic  empty,
  // Pop served from the RAM
  output logic  ram_rd_beat
);

  // ----------------------------------------
  // Flow control
  // ----------------------------------------

  logic  pop_beat;
  addr_t rd_addr;
  addr_t rd_addr_next;

  assign pop_beat = pop_valid && pop_ready;

  // Offer the bypass only when nothing is stored
  assign bypass_ready = empty && pop_ready;

  // ----------------------------------------
  // Output steering
  // ----------------------------------------

  // Empty FIFO forwards the push side as is
  assign pop_valid = !empty || push_valid;
  assign pop_data  = empty ? push_data : ram_rd_data;

  // Bypassed pops leave the RAM alone
  assign ram_rd_beat = pop_beat && !empty;

  // ----------------------------------------
  // Read address counter
  // ----------------------------------------

  assign rd_addr_next = (rd_addr == addr_t'(DEPTH - 1)) ? '0 : rd_addr + 1'b1;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_addr <= '0;
    end else if (ram_rd_beat) begin
      rd_addr <= rd_addr_next;
    end
  end

  // Zero latency read, so the head word is always on ram_rd_data
  assign ram_rd_addr = rd_addr;

endmodule

`default_nettype wire

// File: hdl/fifo_occupancy.sv
// FIFO occupancy tracker
`timescale 1ns/1ps
`default_nettype none

module fifo_occupancy
  import fifo_pkg::*;
(
  input  logic   clk,
  input  logic   rst_n,
  // Beats from the push and pop controllers
  input  logic   wr_beat,
  input  logic   rd_beat,
  // Status
  output count_t items,
  output logic   empty,
  output logic   full
);

  // ----------------------------------------
  // Item counter
  // ----------------------------------------

  count_t items_next;

  always_comb begin
    items_next = items;
    // Write alone grows the count
    if (wr_beat && !rd_beat) begin
      items_next = items + 1'b1;
    end
    // Read alone shrinks it
    if (rd_beat && !wr_beat) begin
      items_next = items - 1'b1;
    end
    // Both or neither leave it unchanged
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      items <= '0;
    end else begin
      items <= items_next;
    end
  end

  // ----------------------------------------
  // Status decode
  // ----------------------------------------

  // From the registered count only
  assign empty = (items == '0);
  assign full  = (items == count_t'(DEPTH));

endmodule

`default_nettype wire

// File: hdl/fifo_top.sv
// FIFO top level
`timescale 1ns/1ps
`default_nettype none

module fifo_top
  import fifo_pkg::*;
(
  input  logic   clk,
  input  logic   rst_n,
  // Push side
  input  logic   push_valid,
  input  data_t  push_data,
  output logic   push_ready,
  // Pop side
  input  logic   pop_ready,
  output logic   pop_valid,
  output data_t  pop_data,
  // Current fill level
  output count_t items
);

  // ----------------------------------------
  // Internal wiring
  // ----------------------------------------

  logic    bypass_ready;
  logic    empty;
  logic    full;
  logic    ram_rd_beat;
  ram_wr_t ram_wr;
  addr_t   ram_rd_addr;
  data_t   ram_rd_data;

  // Push side
  fifo_push_ctrl u_push_ctrl (
    .clk          (clk),
    .rst_n        (rst_n),
    .push_valid   (push_valid),
    .push_data    (push_data),
    .push_ready   (push_ready),
    .full         (full),
    .bypass_ready (bypass_ready),
    .ram_wr       (ram_wr)
  );

  // Pop side with bypass
  fifo_pop_ctrl u_pop_ctrl (
    .clk          (clk),
    .rst_n        (rst_n),
    .pop_ready    (pop_ready),
    .pop_valid    (pop_valid),
    .pop_data     (pop_data),
    .push_valid   (push_valid),
    .push_data    (push_data),
    .bypass_ready (bypass_ready),
    .ram_rd_addr  (ram_rd_addr),
    .ram_rd_data  (ram_rd_data),
    .empty        (empty),
    .ram_rd_beat  (ram_rd_beat)
  );

  // Counts only RAM traffic, bypass leaves it alone
  fifo_occupancy u_occupancy (
    .clk     (clk),
    .rst_n   (rst_n),
    .wr_beat (ram_wr.en),
    .rd_beat (ram_rd_beat),
    .items   (items),
    .empty   (empty),
    .full    (full)
  );

  // Entry storage
  fifo_ram u_ram (
    .clk     (clk),
    .rst_n   (rst_n),
    .ram_wr  (ram_wr),
    .rd_addr (ram_rd_addr),
    .rd_data (ram_rd_data)
  );

endmodule

`default_nettype wire

// File: verification/fifo_clk_gen.sv
// Testbench clock and reset
`timescale 1ns/1ps
`default_nettype none

module fifo_clk_gen (
  output logic clk,
  output logic rst_n
);

  // 100 ns period
  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Held low for two rising edges, released on a falling edge
  initial begin
    rst_n = 1'b0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
  end

endmodule

`default_nettype wire

// File: verification/fifo_props.sv
// FIFO top level assertions
`timescale 1ns/1ps
`default_nettype none

module fifo_props
  import fifo_pkg::*;
(
  input logic   clk,
  input logic   rst_n,
  input logic   push_ready,
  input logic   pop_valid,
  input count_t items
);

  // Assertion failures so far
  int unsigned fail_count = 0;

  // ----------------------------------------
  // Status rules
  // ----------------------------------------

  // Full FIFO refuses pushes, even while popping
  full_blocks_push: assert property (
    @(posedge clk) disable iff (!rst_n)
    (items == count_t'(DEPTH)) |-> !push_ready
  ) else begin
    fail_count++;
    $error("push_ready high with %0d items stored", items);
  end

  // Stored data is always offered
  stored_is_valid: assert property (
    @(posedge clk) disable iff (!rst_n)
    (items != '0) |-> pop_valid
  ) else begin
    fail_count++;
    $error("pop_valid low with %0d items stored", items);
  end

  // Count stays in range
  items_in_range: assert property (
    @(posedge clk) disable iff (!rst_n)
    items <= count_t'(DEPTH)
  ) else begin
    fail_count++;
    $error("items at %0d, above the depth", items);
  end

endmodule

`default_nettype wire

// File: verification/fifo_tb.sv
// FIFO testbench
`timescale 1ns/1ps
`default_nettype none

module fifo_tb
  import fifo_pkg::*;
();

  // One stimulus line, one cycle
  typedef struct packed {
    logic  push_valid;
    data_t push_data;
    logic  pop_ready;
  } stim_t;

  logic   clk;
  logic   rst_n;
  logic   push_valid;
  data_t  push_data;
  logic   push_ready;
  logic   pop_ready;
  logic   pop_valid;
  data_t  pop_data;
  count_t items;

  stim_t  stim_q[$];
  // Reference model, entries held in the RAM
  data_t  model_q[$];
  bit     loaded;

  fifo_clk_gen u_clk_gen (
    .clk   (clk),
    .rst_n (rst_n)
  );

  fifo_top uut (
    .clk        (clk),
    .rst_n      (rst_n),
    .push_valid (push_valid),
    .push_data  (push_data),
    .push_ready (push_ready),
    .pop_ready  (pop_ready),
    .pop_valid  (pop_valid),
    .pop_data   (pop_data),
    .items      (items)
  );

  bind fifo_top fifo_props u_props (
    .clk        (clk),
    .rst_n      (rst_n),
    .push_ready (push_ready),
    .pop_valid  (pop_valid),
    .items      (items)
  );

  // ----------------------------------------
  // Compare tasks
  // ----------------------------------------

  task automatic check_data(input string name, input data_t exp, input data_t act);
    if (act !== exp) begin
      $display("error %s expected %h actual %h", name, exp, act);
      $display("Test FAILED");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  task automatic check_count(input string name, input count_t exp, input count_t act);
    if (act !== exp) begin
      $display("error %s expected %h actual %h", name, exp, act);
      $display("Test FAILED");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("error %s expected %h actual %h", name, exp, act);
      $display("Test FAILED");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  // ----------------------------------------
  // Stimulus file
  // ----------------------------------------

  task automatic load_stim();
    int    fd;
    string line;
    logic  pv;
    data_t pd;
    logic  pr;
    fd = $fopen("verification/fifo_stim.txt", "r");
    if (fd == 0) begin
      $display("could not open the stimulus file");
      $display("Test FAILED");
      $fatal(1, "no stimulus");
    end
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      // Skip comment lines
      if (line.len() > 0 && line.getc(0) != "#") begin
        if ($sscanf(line, "%h %h %h", pv, pd, pr) == 3) begin
          stim_q.push_back('{push_valid: pv, push_data: pd, pop_ready: pr});
        end
      end
    end
    $fclose(fd);
  endtask

  // ----------------------------------------
  // One cycle against the model
  // ----------------------------------------

  task automatic run_cycle(input stim_t s);
    logic exp_ready;
    logic exp_valid;
    logic push_beat;
    logic pop_beat;
    @(negedge clk);
    push_valid = s.push_valid;
    push_data  = s.push_data;
    pop_ready  = s.pop_ready;
    // Let the combinational paths settle, well before the rising edge
    #25;
    exp_ready = (model_q.size() != DEPTH);
    // Empty FIFO only offers what is pushed right now
    exp_valid = (model_q.size() != 0) || s.push_valid;
    check_count("items", count_t'(model_q.size()), items);
    check_flag("push_ready", exp_ready, push_ready);
    check_flag("pop_valid", exp_valid, pop_valid);
    if (exp_valid) begin
      if (model_q.size() != 0) begin
        check_data("pop_data", model_q[0], pop_data);
      end else begin
        check_data("pop_data", s.push_data, pop_data);
      end
    end
    push_beat = s.push_valid && exp_ready;
    pop_beat  = exp_valid && s.pop_ready;
    @(posedge clk);
    // Bypass beat passes straight through and stores nothing
    if (!(model_q.size() == 0 && pop_beat)) begin
      if (pop_beat) begin
        void'(model_q.pop_front());
      end
      if (push_beat) begin
        model_q.push_back(s.push_data);
      end
    end
  endtask

  // ----------------------------------------
  // Main sequence
  // ----------------------------------------

  initial begin
    push_valid = 1'b0;
    push_data  = '0;
    pop_ready  = 1'b0;
    loaded     = 1'b0;
    load_stim();
    loaded = 1'b1;
    wait (rst_n === 1'b1);
    foreach (stim_q[i]) begin
      run_cycle(stim_q[i]);
    end
    // Half a cycle for the bound checker to act on the last edge
    @(negedge clk);
    $display("Test OK");
    $finish;
  end

  // Bound assertion failure ends the run
  initial begin
    wait (uut.u_props.fail_count != 0);
    $display("an assertion in the bound checker failed");
    $display("Test FAILED");
    $fatal(1, "assertion failure");
  end

  // Stimulus length plus 10 cycles of 100 ns
  initial begin
    wait (loaded);
    #((stim_q.size() + 10) * 100);
    $display("watchdog expired before the stimulus was used up");
    $display("Test FAILED");
    $fatal(1, "timeout");
  end

endmodule

`default_nettype wire

// File: verification/fifo_stim.txt
# push_valid push_data pop_ready, hex, one cycle per line
# idle after reset, then bypass, fill, full, overlap, drain
0 00 0
0 00 1
1 a1 1
1 b0 0
1 b1 0
1 b2 0
1 b3 0
1 b4 0
1 b5 0
1 b6 0
1 b7 0
1 b8 0
1 b8 1
1 b8 1
1 b9 1
1 ba 1
1 bb 1
0 00 1
0 00 1
0 00 1
0 00 1
0 00 1
0 00 1
0 00 1
0 00 1

// File: all.f
hdl/fifo_pkg.sv
hdl/fifo_ram.sv
hdl/fifo_push_ctrl.sv
hdl/fifo_pop_ctrl.sv
hdl/fifo_occupancy.sv
hdl/fifo_top.sv
verification/fifo_clk_gen.sv
verification/fifo_props.sv
verification/fifo_tb.sv

// File: Bender.yml
package:
  name: fifo

sources:
  - hdl/fifo_pkg.sv
  - hdl/fifo_ram.sv
  - hdl/fifo_push_ctrl.sv
  - hdl/fifo_pop_ctrl.sv
  - hdl/fifo_occupancy.sv
  - hdl/fifo_top.sv
  - target: test
    files:
      - verification/fifo_clk_gen.sv
      - verification/fifo_props.sv
      - verification/fifo_tb.sv
